/* fix_tx.f */
+incdir+bench
logic/fix_pkg.sv
logic/fix_session_regs.sv
logic/fix_body_length.sv
logic/fix_checksum.sv
logic/fix_field_serializer.sv
logic/fix_field_sequencer.sv
logic/fix_tx_top.sv
bench/fix_tx_tb.sv

/* Makefile */
# Verilator build and run for the FIX transmitter testbench

TOP ?= fix_tx_tb
RTL_TOP ?= fix_tx_top
FILELIST ?= fix_tx.f
LOG ?= sim.log
TIMEOUT ?= 300
OBJ_DIR ?= obj_dir
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

run: build
	-timeout $(TIMEOUT) ./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/fix_tx_tb_tasks.svh */
/*
  included inside fix_tx_tb and uses its signals, session strings and LFSR state
  AXI tasks start on a clock edge and return on the edge that completes the response
*/
`ifndef FIX_TX_TB_TASKS_SVH
`define FIX_TX_TB_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

function automatic logic rand_bit();
	lfsr_q = lfsr_step(lfsr_q);
	return lfsr_q[0];
endfunction

function automatic logic [31:0] take_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], rand_bit()};
	end
	return r;
endfunction

task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
	@(posedge clk);
	s_awaddr_i <= addr;
	s_awvalid_i <= 1'b1;
	s_wdata_i <= data;
	s_wstrb_i <= 4'hf;
	s_wvalid_i <= 1'b1;
	do @(posedge clk); while (!s_awready_o);
	s_awvalid_i <= 1'b0;
	s_wvalid_i <= 1'b0;
	do @(posedge clk); while (!s_bvalid_o);
endtask

task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
	@(posedge clk);
	s_araddr_i <= addr;
	s_arvalid_i <= 1'b1;
	do @(posedge clk); while (!s_arready_o);
	s_arvalid_i <= 1'b0;
	do @(posedge clk); while (!s_rvalid_o);
	data = s_rdata_o;
endtask

task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp, input string name);
	logic [31:0] got;
	read_reg(addr, got);
	assert (got == exp) else begin
		errors++;
		$display("** Error at %0t ns: s_rdata_o (%s) = 0x%h, expected 0x%h",
			$time, name, got, exp);
	end
endtask

// register image of a value, first character in the lowest byte
function automatic logic [31:0] pack_word(input string s, input int w);
	logic [31:0] word;
	word = '0;
	for (int b = 0; b < 4; b++) begin
		if (4*w + b < s.len()) begin
			word[8*b +: 8] = s[4*w + b];
		end
	end
	return word;
endfunction

function automatic logic [31:0] lens_word();
	return {8'(hb_s.len()), 8'(time_s.len()), 8'(target_s.len()), 8'(sender_s.len())};
endfunction

function automatic logic [31:0] to_bcd(input int n);
	logic [31:0] r;
	int v;
	r = '0;
	v = n;
	for (int d = 0; d < 6; d++) begin
		r[4*d +: 4] = 4'(v % 10);
		v = v / 10;
	end
	return r;
endfunction

// digits in the shape of a FIX UTC timestamp
function automatic string make_time();
	string s;
	s = "";
	for (int i = 0; i < 17; i++) begin
		if (i == 8) begin
			s = {s, "-"};
		end else if (i == 11 || i == 14) begin
			s = {s, ":"};
		end else begin
			s = {s, $sformatf("%0d", take_bits(4) % 10)};
		end
	end
	return s;
endfunction

// whole message from the FIX rules, type 0 heartbeat, 1 logon, 2 logout
function automatic string build_msg(input int mtype, input int seq);
	string tchar;
	string body;
	string head;
	string msg;
	int sum;
	case (mtype)
		1: tchar = "A";
		2: tchar = "5";
		default: tchar = "0";
	endcase
	body = $sformatf("35=%s%c34=%06d%c49=%s%c52=%s%c56=%s%c", tchar, fix_pkg::FIX_SOH,
		seq, fix_pkg::FIX_SOH, sender_s, fix_pkg::FIX_SOH, time_s, fix_pkg::FIX_SOH,
		target_s, fix_pkg::FIX_SOH);
	if (mtype == 1) begin
		body = {body, $sformatf("98=0%c108=%s%c", fix_pkg::FIX_SOH, hb_s, fix_pkg::FIX_SOH)};
	end
	head = $sformatf("8=FIX.4.2%c9=%03d%c", fix_pkg::FIX_SOH, body.len(), fix_pkg::FIX_SOH);
	msg = {head, body};
	sum = 0;
	for (int i = 0; i < msg.len(); i++) begin
		sum += msg[i];
	end
	return {msg, $sformatf("10=%03d%c", sum % 256, fix_pkg::FIX_SOH)};
endfunction

`endif

/* bench/fix_tx_tb.sv */
/*
  drives session setup over AXI4-Lite and compares the byte stream with messages
  built from the FIX rules; sender and target are fixed, the sending time is random
*/
`timescale 1ns/1ns

module fix_tx_tb;

	logic clk = 1'b0;
	logic rst;
	logic [fix_pkg::AXI_ADDR_W-1:0] s_awaddr_i;
	logic s_awvalid_i;
	logic s_awready_o;
	logic [fix_pkg::AXI_DATA_W-1:0] s_wdata_i;
	logic [fix_pkg::AXI_DATA_W/8-1:0] s_wstrb_i;
	logic s_wvalid_i;
	logic s_wready_o;
	logic [1:0] s_bresp_o;
	logic s_bvalid_o;
	logic s_bready_i;
	logic [fix_pkg::AXI_ADDR_W-1:0] s_araddr_i;
	logic s_arvalid_i;
	logic s_arready_o;
	logic [fix_pkg::AXI_DATA_W-1:0] s_rdata_o;
	logic [1:0] s_rresp_o;
	logic s_rvalid_o;
	logic s_rready_i;
	logic [7:0] out_data_o;
	logic out_valid_o;
	logic out_last_o;
	logic out_ready_i;

	logic [31:0] lfsr_q = 32'h6bc0;
	string sender_s;
	string target_s;
	string time_s;
	string hb_s;
	int errors = 0;
	int test_cnt = 0;
	int fail_cnt = 0;
	int err_base = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int seq_num = 0;
	int rx_goal = 0;
	int last_len = 0;
	int rx_cnt;

	// stream model, {last, byte} per entry
	logic [8:0] exp_q[$];
	logic [7:0] exp_byte;
	logic exp_last;
	logic exp_valid;

	`include "fix_tx_tb_tasks.svh"

	task automatic send_msg(input int mtype, input int seq);
		string m;
		logic [31:0] ctrl;
		m = build_msg(mtype, seq);
		for (int i = 0; i < m.len(); i++) begin
			exp_q.push_back({i == m.len() - 1, m[i]});
		end
		last_len = m.len();
		rx_goal += m.len();
		ctrl = 32'd1;
		ctrl[9:8] = 2'(mtype);
		write_reg(fix_pkg::REG_CTRL, ctrl);
	endtask

	task automatic wait_msg();
		while (rx_cnt < rx_goal) begin
			@(posedge clk);
		end
	endtask

	task automatic load_config(input int seq);
		for (int w = 0; w < 5; w++) begin
			write_reg(fix_pkg::REG_SENDER + 12'(4*w), pack_word(sender_s, w));
			write_reg(fix_pkg::REG_TARGET + 12'(4*w), pack_word(target_s, w));
			write_reg(fix_pkg::REG_TIME + 12'(4*w), pack_word(time_s, w));
		end
		write_reg(fix_pkg::REG_LENS, lens_word());
		write_reg(fix_pkg::REG_HBINT, pack_word(hb_s, 0));
		write_reg(fix_pkg::REG_SEQ, to_bcd(seq));
	endtask

	task automatic start_test();
		err_base = errors;
	endtask

	task automatic report_test(input string name);
		test_cnt++;
		if (errors != err_base) begin
			fail_cnt++;
			$display("test %0d (%s) had %0d errors", test_cnt, name, errors - err_base);
		end else begin
			$display("test %0d (%s) passed", test_cnt, name);
		end
	endtask

	fix_tx_top uut (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		if (rst) begin
			rx_cnt <= 0;
			exp_valid <= 1'b0;
		end else begin
			if (out_valid_o && out_ready_i) begin
				rx_cnt <= rx_cnt + 1;
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
			end
			exp_valid <= (exp_q.size() > 0);
			if (exp_q.size() > 0) begin
				{exp_last, exp_byte} <= exp_q[0];
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) out_valid_o && out_ready_i |-> exp_valid)
	else begin
		errors++;
		$display("byte 0x%h was accepted at %0t ns while no byte was expected",
			$sampled(out_data_o), $time);
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid_o && out_ready_i && exp_valid |-> out_data_o == exp_byte)
	else begin
		errors++;
		$display("** Error at %0t ns: out_data_o = 0x%h, expected 0x%h",
			$time, $sampled(out_data_o), $sampled(exp_byte));
	end

	assert property (@(posedge clk) disable iff (rst)
		out_valid_o && out_ready_i && exp_valid |-> out_last_o == exp_last)
	else begin
		errors++;
		$display("** Error at %0t ns: out_last_o = %b, expected %b",
			$time, $sampled(out_last_o), $sampled(exp_last));
	end

	// address and data are taken together
	assert property (@(posedge clk) disable iff (rst) s_wready_o == s_awready_o)
	else begin
		errors++;
		$display("** Error at %0t ns: s_wready_o = %b, expected %b",
			$time, $sampled(s_wready_o), $sampled(s_awready_o));
	end

	assert property (@(posedge clk) disable iff (rst) s_bvalid_o |-> s_bresp_o == 2'b00)
	else begin
		errors++;
		$display("** Error at %0t ns: s_bresp_o = %b, expected 00",
			$time, $sampled(s_bresp_o));
	end

	assert property (@(posedge clk) disable iff (rst) s_rvalid_o |-> s_rresp_o == 2'b00)
	else begin
		errors++;
		$display("** Error at %0t ns: s_rresp_o = %b, expected 00",
			$time, $sampled(s_rresp_o));
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run stopped after %0d cycles without reaching the end", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin : main
		int mid_mark;
		int late_mark;
		bit mid_done;
		bit late_done;
		rst <= 1'b1;
		s_awaddr_i <= '0;
		s_awvalid_i <= 1'b0;
		s_wdata_i <= '0;
		s_wstrb_i <= '0;
		s_wvalid_i <= 1'b0;
		s_bready_i <= 1'b1;
		s_araddr_i <= '0;
		s_arvalid_i <= 1'b0;
		s_rready_i <= 1'b1;
		out_ready_i <= 1'b0;
		sender_s = "CLIENT7";
		target_s = "VENUE42";
		hb_s = "30";
		time_s = make_time();
		// five heartbeats, one logon, one logout
		cycle_limit = 4 * (5 * build_msg(0, 0).len() + build_msg(1, 0).len()
			+ build_msg(2, 0).len()) + 2000;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		out_ready_i <= 1'b1;

		start_test();
		seq_num = 41;
		load_config(seq_num);
		check_reg(fix_pkg::REG_SENDER, pack_word(sender_s, 0), "SENDER[0]");
		check_reg(fix_pkg::REG_SENDER + 12'd4, pack_word(sender_s, 1), "SENDER[1]");
		check_reg(fix_pkg::REG_TARGET + 12'd4, pack_word(target_s, 1), "TARGET[1]");
		check_reg(fix_pkg::REG_TIME + 12'd16, pack_word(time_s, 4), "TIME[4]");
		check_reg(fix_pkg::REG_LENS, lens_word(), "LENS");
		check_reg(fix_pkg::REG_HBINT, pack_word(hb_s, 0), "HBINT");
		check_reg(fix_pkg::REG_SEQ, to_bcd(seq_num), "SEQ");
		check_reg(12'h0a0, 32'd0, "unmapped 0x0a0");
		check_reg(12'h034, 32'd0, "unmapped 0x034");
		report_test("register access");

		start_test();
		send_msg(0, seq_num);
		seq_num++;
		wait_msg();
		check_reg(fix_pkg::REG_STATUS, 32'd0, "STATUS");
		report_test("heartbeat");

		start_test();
		send_msg(1, seq_num);
		seq_num++;
		wait_msg();
		check_reg(fix_pkg::REG_STATUS, 32'd0, "STATUS");
		report_test("logon");

		// random out_ready_i, busy probed mid message and with one byte left
		start_test();
		out_ready_i <= 1'b0;
		send_msg(2, seq_num);
		seq_num++;
		mid_mark = rx_goal - last_len / 2;
		late_mark = rx_goal - 2;
		mid_done = 1'b0;
		late_done = 1'b0;
		while (rx_cnt < rx_goal) begin
			@(posedge clk);
			if ((rx_cnt == mid_mark && !mid_done) || (rx_cnt == late_mark && !late_done)) begin
				mid_done = mid_done || (rx_cnt == mid_mark);
				late_done = late_done || (rx_cnt == late_mark);
				out_ready_i <= 1'b0;
				check_reg(fix_pkg::REG_STATUS, 32'd1, "STATUS while sending");
			end else begin
				out_ready_i <= rand_bit();
			end
		end
		out_ready_i <= 1'b1;
		check_reg(fix_pkg::REG_STATUS, 32'd0, "STATUS");
		report_test("logout with back-pressure");

		start_test();
		seq_num = 9;
		write_reg(fix_pkg::REG_SEQ, to_bcd(seq_num));
		repeat (3) begin
			send_msg(0, seq_num);
			seq_num++;
			wait_msg();
		end
		check_reg(fix_pkg::REG_SEQ, to_bcd(12), "SEQ");
		report_test("sequence number");

		// second CTRL write asks for a logon while the heartbeat is still going
		start_test();
		send_msg(0, seq_num);
		seq_num++;
		write_reg(fix_pkg::REG_CTRL, 32'h0000_0101);
		wait_msg();
		repeat (200) @(posedge clk);
		assert (rx_cnt == rx_goal) else begin
			errors++;
			$display("%0d bytes came out after a send while busy, %0d were expected",
				rx_cnt, rx_goal);
		end
		check_reg(fix_pkg::REG_SEQ, to_bcd(seq_num), "SEQ");
		check_reg(fix_pkg::REG_CTRL, 32'd0, "CTRL");
		report_test("send while busy");

		$display("%0d tests run, %0d with errors, %0d failed checks", test_cnt, fail_cnt, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* logic/fix_tx_top.sv */
/*
  FIX session message transmitter, AXI4-Lite setup and one byte stream out
*/
`timescale 1ns/1ns

module fix_tx_top (
	input logic clk,
	input logic rst,
	input logic [fix_pkg::AXI_ADDR_W-1:0] s_awaddr_i,
	input logic s_awvalid_i,
	output logic s_awready_o,
	input logic [fix_pkg::AXI_DATA_W-1:0] s_wdata_i,
	input logic [fix_pkg::AXI_DATA_W/8-1:0] s_wstrb_i,
	input logic s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input logic s_bready_i,
	input logic [fix_pkg::AXI_ADDR_W-1:0] s_araddr_i,
	input logic s_arvalid_i,
	output logic s_arready_o,
	output logic [fix_pkg::AXI_DATA_W-1:0] s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input logic s_rready_i,
	output logic [7:0] out_data_o,
	output logic out_valid_o,
	output logic out_last_o,
	input logic out_ready_i
);

	fix_pkg::fix_cfg_t cfg;
	fix_pkg::fix_msg_e msg_type;
	fix_pkg::fix_field_t fld;
	logic send;
	logic msg_done;
	logic [23:0] len_ascii;
	logic len_valid;
	logic [23:0] sum_ascii;
	logic fld_valid;
	logic fld_ready;
	logic [7:0] sum_byte;
	logic sum_valid;
	logic last_accepted;

	fix_session_regs u_regs (
		.clk(clk),
		.rst(rst),
		.s_awaddr_i(s_awaddr_i),
		.s_awvalid_i(s_awvalid_i),
		.s_awready_o(s_awready_o),
		.s_wdata_i(s_wdata_i),
		.s_wstrb_i(s_wstrb_i),
		.s_wvalid_i(s_wvalid_i),
		.s_wready_o(s_wready_o),
		.s_bresp_o(s_bresp_o),
		.s_bvalid_o(s_bvalid_o),
		.s_bready_i(s_bready_i),
		.s_araddr_i(s_araddr_i),
		.s_arvalid_i(s_arvalid_i),
		.s_arready_o(s_arready_o),
		.s_rdata_o(s_rdata_o),
		.s_rresp_o(s_rresp_o),
		.s_rvalid_o(s_rvalid_o),
		.s_rready_i(s_rready_i),
		.msg_done_i(msg_done),
		.cfg_o(cfg),
		.msg_type_o(msg_type),
		.send_o(send)
	);

	fix_body_length u_body_length (
		.clk(clk),
		.rst(rst),
		.send_i(send),
		.msg_type_i(msg_type),
		.cfg_i(cfg),
		.len_ascii_o(len_ascii),
		.len_valid_o(len_valid)
	);

	fix_checksum u_checksum (
		.clk(clk),
		.rst(rst),
		.clear_i(send),
		.byte_i(sum_byte),
		.byte_valid_i(sum_valid),
		.sum_ascii_o(sum_ascii)
	);

	fix_field_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.send_i(send),
		.msg_type_i(msg_type),
		.cfg_i(cfg),
		.len_ascii_i(len_ascii),
		.len_valid_i(len_valid),
		.sum_ascii_i(sum_ascii),
		.fld_o(fld),
		.fld_valid_o(fld_valid),
		.fld_ready_i(fld_ready),
		.last_accepted_i(last_accepted),
		.msg_done_o(msg_done)
	);

	fix_field_serializer u_serializer (
		.clk(clk),
		.rst(rst),
		.fld_i(fld),
		.fld_valid_i(fld_valid),
		.fld_ready_o(fld_ready),
		.out_data_o(out_data_o),
		.out_valid_o(out_valid_o),
		.out_last_o(out_last_o),
		.out_ready_i(out_ready_i),
		.sum_byte_o(sum_byte),
		.sum_valid_o(sum_valid),
		.last_accepted_o(last_accepted)
	);

endmodule

/* logic/fix_field_sequencer.sv */
/*
  fields go out as 8, 9, 35, 34, 49, 52, 56, then 98 and 108 on logon, then 10
  field 8 waits for BodyLength; CheckSum follows one idle cycle after the body
*/
`timescale 1ns/1ns

module fix_field_sequencer (
	input logic clk,
	input logic rst,
	input logic send_i,
	input fix_pkg::fix_msg_e msg_type_i,
	input fix_pkg::fix_cfg_t cfg_i,
	input logic [23:0] len_ascii_i,
	input logic len_valid_i,
	input logic [23:0] sum_ascii_i,
	output fix_pkg::fix_field_t fld_o,
	output logic fld_valid_o,
	input logic fld_ready_i,
	input logic last_accepted_i,
	output logic msg_done_o
);

	typedef enum logic [3:0] {
		S_IDLE, S_8, S_9, S_35, S_34, S_49, S_52, S_56, S_98, S_108, S_10, S_WAIT
	} seq_state_e;

	seq_state_e state_q;
	seq_state_e state_next;
	fix_pkg::fix_field_t fld_next;
	logic [7:0] type_char;
	logic slot_free;
	logic gate;
	logic logon;

	assign logon = (msg_type_i == fix_pkg::MSG_LOGON);
	assign slot_free = !fld_valid_o || fld_ready_i;
	assign msg_done_o = (state_q == S_WAIT) && last_accepted_i;

	always_comb begin
		case (msg_type_i)
			fix_pkg::MSG_LOGON: type_char = fix_pkg::FIX_TYPE_LOGON;
			fix_pkg::MSG_LOGOUT: type_char = fix_pkg::FIX_TYPE_LOGOUT;
			default: type_char = fix_pkg::FIX_TYPE_HB;
		endcase
	end

	// checksum only once the serializer has drained the body
	always_comb begin
		case (state_q)
			S_8, S_9: gate = len_valid_i;
			S_10: gate = !fld_valid_o && fld_ready_i;
			S_IDLE, S_WAIT: gate = 1'b0;
			default: gate = 1'b1;
		endcase
	end

	always_comb begin
		fld_next = '0;
		fld_next.tag_len = 2'd2;
		fld_next.sum_en = 1'b1;
		state_next = state_q;
		case (state_q)
			S_8: begin
				fld_next.tag = fix_pkg::TAG_BEGIN;
				fld_next.tag_len = 2'd1;
				for (int i = 0; i < fix_pkg::FIX_BEGIN_LEN; i++) begin
					fld_next.val[8*i +: 8] =
						fix_pkg::FIX_BEGIN_STRING[8*(fix_pkg::FIX_BEGIN_LEN-1-i) +: 8];
				end
				fld_next.val_len = 5'd7;
				state_next = S_9;
			end
			S_9: begin
				fld_next.tag = fix_pkg::TAG_BODYLEN;
				fld_next.tag_len = 2'd1;
				fld_next.val[23:0] = len_ascii_i;
				fld_next.val_len = 5'd3;
				state_next = S_35;
			end
			S_35: begin
				fld_next.tag = fix_pkg::TAG_MSGTYPE;
				fld_next.val[7:0] = type_char;
				fld_next.val_len = 5'd1;
				state_next = S_34;
			end
			S_34: begin
				// most significant BCD digit first
				fld_next.tag = fix_pkg::TAG_SEQNUM;
				for (int i = 0; i < 6; i++) begin
					fld_next.val[8*i +: 8] = {4'h3, cfg_i.seq[4*(5-i) +: 4]};
				end
				fld_next.val_len = 5'd6;
				state_next = S_49;
			end
			S_49: begin
				fld_next.tag = fix_pkg::TAG_SENDER;
				fld_next.val = cfg_i.sender;
				fld_next.val_len = cfg_i.sender_len;
				state_next = S_52;
			end
			S_52: begin
				fld_next.tag = fix_pkg::TAG_TIME;
				fld_next.val = cfg_i.sendtime;
				fld_next.val_len = cfg_i.time_len;
				state_next = S_56;
			end
			S_56: begin
				fld_next.tag = fix_pkg::TAG_TARGET;
				fld_next.val = cfg_i.target;
				fld_next.val_len = cfg_i.target_len;
				state_next = logon ? S_98 : S_10;
			end
			S_98: begin
				fld_next.tag = fix_pkg::TAG_ENCRYPT;
				fld_next.val[7:0] = 8'h30;
				fld_next.val_len = 5'd1;
				state_next = S_108;
			end
			S_108: begin
				fld_next.tag = fix_pkg::TAG_HBINT;
				fld_next.tag_len = 2'd3;
				fld_next.val[31:0] = cfg_i.hbint;
				fld_next.val_len = {2'b00, cfg_i.hb_len};
				state_next = S_10;
			end
			S_10: begin
				fld_next.tag = fix_pkg::TAG_CHECKSUM;
				fld_next.val[23:0] = sum_ascii_i;
				fld_next.val_len = 5'd3;
				fld_next.sum_en = 1'b0;
				fld_next.last = 1'b1;
				state_next = S_WAIT;
			end
			default: fld_next = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= S_IDLE;
			fld_valid_o <= 1'b0;
		end else begin
			if (fld_valid_o && fld_ready_i) begin
				fld_valid_o <= 1'b0;
			end
			case (state_q)
				S_IDLE: begin
					if (send_i) begin
						state_q <= S_8;
					end
				end
				S_WAIT: begin
					if (last_accepted_i) begin
						state_q <= S_IDLE;
					end
				end
				default: begin
					if (slot_free && gate) begin
						state_q <= state_next;
						fld_valid_o <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (slot_free && gate) begin
			fld_o <= fld_next;
		end
	end

	// the serializer reports a final byte only for field 10
	assert property (@(posedge clk) disable iff (rst)
		last_accepted_i |-> (state_q == S_WAIT));

endmodule

/* logic/fix_field_serializer.sv */
/*
  one field is held at a time, the next is taken as the SOH of the held one goes out
  tag and value lengths must be at least one
*/
`timescale 1ns/1ns

module fix_field_serializer (
	input logic clk,
	input logic rst,
	input fix_pkg::fix_field_t fld_i,
	input logic fld_valid_i,
	output logic fld_ready_o,
	output logic [7:0] out_data_o,
	output logic out_valid_o,
	output logic out_last_o,
	input logic out_ready_i,
	output logic [7:0] sum_byte_o,
	output logic sum_valid_o,
	output logic last_accepted_o
);

	fix_pkg::fix_field_t hold_q;
	logic full_q;
	logic [4:0] idx_q;
	logic [4:0] tag_end;
	logic [4:0] val_pos;
	logic [4:0] soh_pos;
	logic [4:0] val_off;
	logic at_end;
	logic accept;

	// byte positions within "tag=value" SOH
	assign tag_end = {3'b000, hold_q.tag_len};
	assign val_pos = tag_end + 5'd1;
	assign soh_pos = val_pos + hold_q.val_len;
	assign val_off = idx_q - val_pos;
	assign at_end = (idx_q == soh_pos);

	always_comb begin
		if (idx_q < tag_end) begin
			out_data_o = hold_q.tag[23 - 8*idx_q -: 8];
		end else if (idx_q == tag_end) begin
			out_data_o = fix_pkg::FIX_EQUALS;
		end else if (idx_q < soh_pos) begin
			out_data_o = hold_q.val[8*val_off +: 8];
		end else begin
			out_data_o = fix_pkg::FIX_SOH;
		end
	end

	assign accept = full_q && out_ready_i;
	assign out_valid_o = full_q;
	assign out_last_o = full_q && hold_q.last && at_end;
	assign fld_ready_o = !full_q || (accept && at_end);
	assign sum_byte_o = out_data_o;
	assign sum_valid_o = accept && hold_q.sum_en;
	assign last_accepted_o = accept && at_end && hold_q.last;

	always_ff @(posedge clk) begin
		if (rst) begin
			full_q <= 1'b0;
			idx_q <= '0;
		end else if (fld_valid_i && fld_ready_o) begin
			full_q <= 1'b1;
			idx_q <= '0;
		end else if (accept) begin
			if (at_end) begin
				full_q <= 1'b0;
			end else begin
				idx_q <= idx_q + 5'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fld_valid_i && fld_ready_o) begin
			hold_q <= fld_i;
		end
	end

	// a field waiting for the slot stays offered and unchanged
	assert property (@(posedge clk) disable iff (rst)
		fld_valid_i && !fld_ready_o |=> fld_valid_i && $stable(fld_i));

endmodule

/* logic/fix_checksum.sv */
/*
  sum_ascii_o already includes the byte strobed in the current cycle
  hundreds digit sits in the lowest byte
*/
`timescale 1ns/1ns

module fix_checksum (
	input logic clk,
	input logic rst,
	input logic clear_i,
	input logic [7:0] byte_i,
	input logic byte_valid_i,
	output logic [23:0] sum_ascii_o
);

	logic [7:0] sum_q;
	logic [7:0] sum_now;
	logic [7:0] hund;
	logic [7:0] tens;
	logic [7:0] units;

	assign sum_now = sum_q + (byte_valid_i ? byte_i : 8'h00);

	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			sum_q <= 8'h00;
		end else begin
			sum_q <= sum_now;
		end
	end

	// constant divisors only
	assign hund = sum_now / 8'd100;
	assign tens = (sum_now / 8'd10) % 8'd10;
	assign units = sum_now % 8'd10;
	assign sum_ascii_o = {8'h30 + units, 8'h30 + tens, 8'h30 + hund};

endmodule

/* logic/fix_body_length.sv */
/*
  BodyLength covers 35, 34, 49, 52, 56 and on logon 98 and 108, result below 1000
  len_ascii_o carries the hundreds digit in the lowest byte
*/
`timescale 1ns/1ns

module fix_body_length (
	input logic clk,
	input logic rst,
	input logic send_i,
	input fix_pkg::fix_msg_e msg_type_i,
	input fix_pkg::fix_cfg_t cfg_i,
	output logic [23:0] len_ascii_o,
	output logic len_valid_o
);

	typedef enum logic [1:0] {BL_IDLE, BL_SUM, BL_CONV} bl_state_e;

	bl_state_e state_q;
	logic [2:0] idx_q;
	logic [9:0] sum_q;
	logic [3:0] hund_q;
	logic [3:0] tens_q;
	logic [9:0] field_len;
	logic logon;

	assign logon = (msg_type_i == fix_pkg::MSG_LOGON);

	// tag, "=", value and SOH of one body field
	always_comb begin
		case (idx_q)
			3'd0: field_len = 10'd5;
			3'd1: field_len = 10'd10;
			3'd2: field_len = 10'd4 + cfg_i.sender_len;
			3'd3: field_len = 10'd4 + cfg_i.time_len;
			3'd4: field_len = 10'd4 + cfg_i.target_len;
			3'd5: field_len = logon ? 10'd5 : 10'd0;
			3'd6: field_len = logon ? 10'd5 + cfg_i.hb_len : 10'd0;
			default: field_len = 10'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= BL_IDLE;
			len_valid_o <= 1'b0;
			idx_q <= '0;
			sum_q <= '0;
			hund_q <= '0;
			tens_q <= '0;
		end else if (send_i) begin
			state_q <= BL_SUM;
			len_valid_o <= 1'b0;
			idx_q <= '0;
			sum_q <= '0;
			hund_q <= '0;
			tens_q <= '0;
		end else if (state_q == BL_SUM) begin
			sum_q <= sum_q + field_len;
			idx_q <= idx_q + 3'd1;
			if (idx_q == 3'd6) begin
				state_q <= BL_CONV;
			end
		end else if (state_q == BL_CONV) begin
			// repeated subtraction, units remain in sum_q
			if (sum_q >= 10'd100) begin
				sum_q <= sum_q - 10'd100;
				hund_q <= hund_q + 4'd1;
			end else if (sum_q >= 10'd10) begin
				sum_q <= sum_q - 10'd10;
				tens_q <= tens_q + 4'd1;
			end else begin
				state_q <= BL_IDLE;
				len_valid_o <= 1'b1;
			end
		end
	end

	assign len_ascii_o = {4'h3, sum_q[3:0], 4'h3, tens_q, 4'h3, hund_q};

	// configured lengths must fit their value fields
	assert property (@(posedge clk) disable iff (rst)
		(state_q == BL_SUM) |-> (cfg_i.sender_len <= 5'(fix_pkg::FIX_VAL_BYTES))
			&& (cfg_i.target_len <= 5'(fix_pkg::FIX_VAL_BYTES))
			&& (cfg_i.time_len <= 5'(fix_pkg::FIX_VAL_BYTES))
			&& (cfg_i.hb_len <= 3'(fix_pkg::FIX_HB_BYTES)));

endmodule

/* logic/fix_session_regs.sv */
/*
  the AXI master must hold awvalid and wvalid together until both readies are seen
  config and CTRL writes are dropped while a message is in progress
*/
`timescale 1ns/1ns

module fix_session_regs (
	input logic clk,
	input logic rst,
	input logic [fix_pkg::AXI_ADDR_W-1:0] s_awaddr_i,
	input logic s_awvalid_i,
	output logic s_awready_o,
	input logic [fix_pkg::AXI_DATA_W-1:0] s_wdata_i,
	input logic [fix_pkg::AXI_DATA_W/8-1:0] s_wstrb_i,
	input logic s_wvalid_i,
	output logic s_wready_o,
	output logic [1:0] s_bresp_o,
	output logic s_bvalid_o,
	input logic s_bready_i,
	input logic [fix_pkg::AXI_ADDR_W-1:0] s_araddr_i,
	input logic s_arvalid_i,
	output logic s_arready_o,
	output logic [fix_pkg::AXI_DATA_W-1:0] s_rdata_o,
	output logic [1:0] s_rresp_o,
	output logic s_rvalid_o,
	input logic s_rready_i,
	input logic msg_done_i,
	output fix_pkg::fix_cfg_t cfg_o,
	output fix_pkg::fix_msg_e msg_type_o,
	output logic send_o
);

	logic wr_en;
	logic rd_en;
	logic cfg_we;
	logic busy_q;
	logic [11:0] waddr;
	logic [11:0] raddr;
	logic [23:0] seq_q;
	logic [31:0] seq_wr;
	logic [31:0] lens_q;
	logic [31:0] hbint_q;
	logic [31:0] rd_word;
	logic [4:0][31:0] sender_q;
	logic [4:0][31:0] target_q;
	logic [4:0][31:0] time_q;

	function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				res[8*i +: 8] = data[8*i +: 8];
			end
		end
		return res;
	endfunction

	// six BCD digits with decimal carry
	function automatic logic [23:0] bcd_inc(input logic [23:0] v);
		logic [23:0] res;
		logic carry;
		res = v;
		carry = 1'b1;
		for (int d = 0; d < 6; d++) begin
			if (carry) begin
				if (res[4*d +: 4] == 4'd9) begin
					res[4*d +: 4] = 4'd0;
				end else begin
					res[4*d +: 4] = res[4*d +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return res;
	endfunction

	assign waddr = {s_awaddr_i[11:2], 2'b00};
	assign raddr = {s_araddr_i[11:2], 2'b00};
	assign wr_en = s_awready_o && s_awvalid_i && s_wready_o && s_wvalid_i;
	assign rd_en = s_arready_o && s_arvalid_i;
	assign cfg_we = wr_en && !busy_q;
	assign send_o = cfg_we && (waddr == fix_pkg::REG_CTRL) && s_wstrb_i[0] && s_wdata_i[0];
	assign seq_wr = merge({8'h00, seq_q}, s_wdata_i, s_wstrb_i);
	assign s_bresp_o = 2'b00;
	assign s_rresp_o = 2'b00;

	always_ff @(posedge clk) begin
		if (rst) begin
			s_awready_o <= 1'b0;
			s_wready_o <= 1'b0;
			s_bvalid_o <= 1'b0;
			s_arready_o <= 1'b0;
			s_rvalid_o <= 1'b0;
		end else begin
			s_awready_o <= s_awvalid_i && s_wvalid_i && !s_awready_o && !s_bvalid_o;
			s_wready_o <= s_awvalid_i && s_wvalid_i && !s_awready_o && !s_bvalid_o;
			if (wr_en) begin
				s_bvalid_o <= 1'b1;
			end else if (s_bready_i) begin
				s_bvalid_o <= 1'b0;
			end
			s_arready_o <= s_arvalid_i && !s_arready_o && !s_rvalid_o;
			if (rd_en) begin
				s_rvalid_o <= 1'b1;
			end else if (s_rready_i) begin
				s_rvalid_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			seq_q <= '0;
			lens_q <= '0;
			hbint_q <= '0;
			msg_type_o <= fix_pkg::MSG_HB;
		end else begin
			if (send_o) begin
				busy_q <= 1'b1;
			end else if (msg_done_i) begin
				busy_q <= 1'b0;
				seq_q <= bcd_inc(seq_q);
			end
			if (cfg_we) begin
				case (waddr)
					fix_pkg::REG_CTRL: begin
						if (s_wstrb_i[1]) begin
							msg_type_o <= fix_pkg::fix_msg_e'(s_wdata_i[9:8]);
						end
					end
					fix_pkg::REG_SEQ: seq_q <= seq_wr[23:0];
					fix_pkg::REG_LENS: lens_q <= merge(lens_q, s_wdata_i, s_wstrb_i);
					fix_pkg::REG_HBINT: hbint_q <= merge(hbint_q, s_wdata_i, s_wstrb_i);
					default: lens_q <= lens_q;
				endcase
			end
		end
	end

	// value words, five per region
	always_ff @(posedge clk) begin
		if (cfg_we && waddr[4:2] < 3'd5) begin
			case (waddr[11:5])
				fix_pkg::REG_SENDER[11:5]:
					sender_q[waddr[4:2]] <= merge(sender_q[waddr[4:2]], s_wdata_i, s_wstrb_i);
				fix_pkg::REG_TARGET[11:5]:
					target_q[waddr[4:2]] <= merge(target_q[waddr[4:2]], s_wdata_i, s_wstrb_i);
				fix_pkg::REG_TIME[11:5]:
					time_q[waddr[4:2]] <= merge(time_q[waddr[4:2]], s_wdata_i, s_wstrb_i);
				default: time_q <= time_q;
			endcase
		end
	end

	always_comb begin
		rd_word = '0;
		case (raddr)
			fix_pkg::REG_CTRL: rd_word = {22'd0, msg_type_o, 8'd0};
			fix_pkg::REG_STATUS: rd_word = {31'd0, busy_q};
			fix_pkg::REG_SEQ: rd_word = {8'd0, seq_q};
			fix_pkg::REG_LENS: rd_word = lens_q;
			fix_pkg::REG_HBINT: rd_word = hbint_q;
			default: begin
				if (raddr[4:2] < 3'd5) begin
					case (raddr[11:5])
						fix_pkg::REG_SENDER[11:5]: rd_word = sender_q[raddr[4:2]];
						fix_pkg::REG_TARGET[11:5]: rd_word = target_q[raddr[4:2]];
						fix_pkg::REG_TIME[11:5]: rd_word = time_q[raddr[4:2]];
						default: rd_word = '0;
					endcase
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			s_rdata_o <= rd_word;
		end
	end

	always_comb begin
		cfg_o.sender = sender_q;
		cfg_o.sender_len = lens_q[4:0];
		cfg_o.target = target_q;
		cfg_o.target_len = lens_q[12:8];
		cfg_o.sendtime = time_q;
		cfg_o.time_len = lens_q[20:16];
		cfg_o.hbint = hbint_q;
		cfg_o.hb_len = lens_q[26:24];
		cfg_o.seq = seq_q;
	end

	// done only ever answers a message in progress
	assert property (@(posedge clk) disable iff (rst) msg_done_i |-> busy_q);

endmodule

/* logic/fix_pkg.sv */
/*
  values are ASCII with the first character in the lowest byte, tags are left-aligned
  every value is limited to FIX_VAL_BYTES characters, the heartbeat interval to four
*/
package fix_pkg;

	localparam int FIX_VAL_BYTES = 20;
	localparam int FIX_LEN_W = 5;
	localparam int FIX_HB_BYTES = 4;
	localparam int AXI_ADDR_W = 12;
	localparam int AXI_DATA_W = 32;

	localparam logic [7:0] FIX_SOH = 8'h01;
	localparam logic [7:0] FIX_EQUALS = 8'h3d;
	localparam logic [55:0] FIX_BEGIN_STRING = "FIX.4.2";
	localparam int FIX_BEGIN_LEN = 7;

	// register byte offsets
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_SEQ = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] REG_LENS = 12'h00c;
	localparam logic [AXI_ADDR_W-1:0] REG_HBINT = 12'h010;
	localparam logic [AXI_ADDR_W-1:0] REG_SENDER = 12'h020;
	localparam logic [AXI_ADDR_W-1:0] REG_TARGET = 12'h040;
	localparam logic [AXI_ADDR_W-1:0] REG_TIME = 12'h060;

	// tags, first character in the top byte
	localparam logic [23:0] TAG_BEGIN = 24'h380000;
	localparam logic [23:0] TAG_BODYLEN = 24'h390000;
	localparam logic [23:0] TAG_MSGTYPE = 24'h333500;
	localparam logic [23:0] TAG_SEQNUM = 24'h333400;
	localparam logic [23:0] TAG_SENDER = 24'h343900;
	localparam logic [23:0] TAG_TIME = 24'h353200;
	localparam logic [23:0] TAG_TARGET = 24'h353600;
	localparam logic [23:0] TAG_ENCRYPT = 24'h393800;
	localparam logic [23:0] TAG_HBINT = 24'h313038;
	localparam logic [23:0] TAG_CHECKSUM = 24'h313000;

	// MsgType characters
	localparam logic [7:0] FIX_TYPE_HB = 8'h30;
	localparam logic [7:0] FIX_TYPE_LOGON = 8'h41;
	localparam logic [7:0] FIX_TYPE_LOGOUT = 8'h35;

	typedef enum logic [1:0] {
		MSG_HB = 2'd0,
		MSG_LOGON = 2'd1,
		MSG_LOGOUT = 2'd2
	} fix_msg_e;

	typedef struct packed {
		logic [23:0] tag;
		logic [1:0] tag_len;
		logic [FIX_VAL_BYTES*8-1:0] val;
		logic [FIX_LEN_W-1:0] val_len;
		logic sum_en;
		logic last;
	} fix_field_t;

	typedef struct packed {
		logic [FIX_VAL_BYTES*8-1:0] sender;
		logic [FIX_LEN_W-1:0] sender_len;
		logic [FIX_VAL_BYTES*8-1:0] target;
		logic [FIX_LEN_W-1:0] target_len;
		logic [FIX_VAL_BYTES*8-1:0] sendtime;
		logic [FIX_LEN_W-1:0] time_len;
		logic [FIX_HB_BYTES*8-1:0] hbint;
		logic [2:0] hb_len;
		logic [23:0] seq;
	} fix_cfg_t;

endpackage
